/* design/pmp_defines.svh */
/*
 * Build-time parameters of the PMP unit. Include wherever the entry count,
 * grain, credit count or CSR addresses are needed.
 */
`ifndef PMP_DEFINES_SVH
`define PMP_DEFINES_SVH

// Number of PMP regions, a multiple of 4
`define PMP_ENTRIES 8

// Minimum region size is 2^(PMP_GRAIN+2) bytes
`define PMP_GRAIN 0

// Response buffer depth and credits granted after reset
`define PMP_CREDITS 4

// Machine-mode CSR addresses
`define PMP_CFG_BASE  12'h3A0
`define PMP_ADDR_BASE 12'h3B0

`endif

/* design/pmp_pkg.sv */
/*
 * Types shared by the PMP CSR file and the check pipeline.
 * Modules import it inside their body.
 */
package pmp_pkg;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_addr_mode_e;

  // One pmpcfg byte, MSB first
  typedef struct packed {
    logic           l;     // Lock, also enforces in M mode
    logic [1:0]     rsvd;  // Always reads zero
    pmp_addr_mode_e a;
    logic           x;
    logic           w;
    logic           r;
  } pmp_cfg_t;

  // A pmpcfgN CSR word holds four entry bytes
  typedef union packed {
    logic [31:0]        raw;
    pmp_cfg_t [3:0]     bytes;  // bytes[0] is the lowest entry
  } pmp_cfg_word_u;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_mode_e;

  typedef enum logic [1:0] {
    ACC_LOAD  = 2'b00,
    ACC_STORE = 2'b01,
    ACC_FETCH = 2'b10
  } access_kind_e;

endpackage

/* design/pmp_csr_file.sv */
/*
 * PMP configuration and address CSRs with WARL and lock filtering.
 * Reads are combinational; writes land on the next rising edge.
 */
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_csr_file (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         i_csr_en,
  input  logic                         i_csr_wen,
  input  logic [11:0]                  i_csr_addr,
  input  logic [31:0]                  i_csr_wdata,
  output logic [31:0]                  o_csr_rdata,
  output logic                         o_csr_ack,
  output logic [8*`PMP_ENTRIES-1:0]    o_cfg_flat,
  output logic [32*`PMP_ENTRIES-1:0]   o_addr_flat
);

  import pmp_pkg::*;

  localparam int CFG_REGS  = `PMP_ENTRIES / 4;
  localparam int CFG_IDX_W = $clog2(CFG_REGS);
  localparam int IDX_W     = $clog2(`PMP_ENTRIES);
  // With a coarse grain the low address bits of a NAPOT region read as ones
  localparam int          GRAIN_ONES = (`PMP_GRAIN > 1) ? `PMP_GRAIN - 1 : 0;
  localparam logic [31:0] GRAIN_MASK = (32'd1 << GRAIN_ONES) - 32'd1;
  localparam logic [31:0] RSVD_MASK  = 32'h6060_6060;

  pmp_cfg_t [`PMP_ENTRIES-1:0]        cfg_q, cfg_d;
  logic [`PMP_ENTRIES-1:0][31:0]      addr_q, addr_d;
  pmp_cfg_word_u                      wdata_u;
  pmp_cfg_word_u                      rdata_u;
  logic [11:0]                        cfg_off, addr_off;
  logic                               cfg_hit, addr_hit;
  logic [CFG_IDX_W-1:0]               cfg_idx;
  logic [IDX_W-1:0]                   addr_idx, next_idx;
  logic                               csr_write;
  logic                               addr_frozen;

  // Legalize one incoming config byte against the stored one
  function automatic pmp_cfg_t warl_cfg(input pmp_cfg_t new_cfg, input pmp_cfg_t old_cfg);
    pmp_cfg_t res;
    res      = new_cfg;
    res.rsvd = 2'b00;
    if (!res.r) begin
      res.w = 1'b0;  // W without R is reserved
    end
    if (`PMP_GRAIN > 0 && res.a == PMP_NA4) begin
      res.a = PMP_NAPOT;
    end
    if (old_cfg.l) begin
      res = old_cfg;
    end
    return res;
  endfunction

  assign cfg_off  = i_csr_addr - `PMP_CFG_BASE;
  assign addr_off = i_csr_addr - `PMP_ADDR_BASE;
  assign cfg_hit  = cfg_off < 12'(CFG_REGS);
  assign addr_hit = addr_off < 12'(`PMP_ENTRIES);
  assign cfg_idx  = cfg_off[CFG_IDX_W-1:0];
  assign addr_idx = addr_off[IDX_W-1:0];
  assign next_idx = addr_idx + 1'b1;
  assign wdata_u.raw = i_csr_wdata;

  assign csr_write = i_csr_en && i_csr_wen;

  // Locked entry, or the entry above is a locked TOR using this address as its base
  assign addr_frozen = cfg_q[addr_idx].l ||
                       (addr_idx != IDX_W'(`PMP_ENTRIES - 1) &&
                        cfg_q[next_idx].l && cfg_q[next_idx].a == PMP_TOR);

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    if (csr_write && cfg_hit) begin
      for (int b = 0; b < 4; b++) begin
        cfg_d[{cfg_idx, 2'(b)}] = warl_cfg(wdata_u.bytes[b], cfg_q[{cfg_idx, 2'(b)}]);
      end
    end
    if (csr_write && addr_hit && !addr_frozen) begin
      addr_d[addr_idx] = i_csr_wdata | GRAIN_MASK;
    end
  end

  // Entries must come up unlocked and OFF
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
    end
  end

  always_comb begin
    rdata_u.raw = 32'd0;
    if (cfg_hit) begin
      for (int b = 0; b < 4; b++) begin
        rdata_u.bytes[b] = cfg_q[{cfg_idx, 2'(b)}];
      end
    end else if (addr_hit) begin
      rdata_u.raw = addr_q[addr_idx];
    end
  end

  assign o_csr_rdata = rdata_u.raw;
  assign o_csr_ack   = i_csr_en && (cfg_hit || addr_hit);  // Unmapped CSRs are not acked
  assign o_cfg_flat  = cfg_q;
  assign o_addr_flat = addr_q;

  // Reserved bits written earlier never come back on a read
  a_rsvd_readback: assert property (@(posedge CLK) disable iff (!nRST)
    (i_csr_en && cfg_hit) |-> ((o_csr_rdata & RSVD_MASK) == 32'd0))
    else $error("pmp_csr_file: reserved cfg bits read back set");

endmodule

/* design/pmp_region_match.sv */
/*
 * Address test for a single PMP region. Purely combinational,
 * one instance per entry in the match stage.
 */
`timescale 1ns/1ps

module pmp_region_match (
  input  logic [29:0]              i_word_addr,
  input  pmp_pkg::pmp_addr_mode_e  i_mode,
  input  logic [31:0]              i_region_addr,
  input  logic [31:0]              i_prev_addr,
  output logic                     o_hit
);

  import pmp_pkg::*;

  logic [31:0] addr;
  logic [31:0] region_inc;
  logic [31:0] napot_span;  // Ones over the bits the region does not compare
  logic        tor_hit;
  logic        na4_hit;
  logic        napot_hit;

  // pmpaddr holds bits [33:2]; top two bits are zero on RV32
  assign addr = {2'b00, i_word_addr};

  assign tor_hit = (addr >= i_prev_addr) && (addr < i_region_addr);
  assign na4_hit = (addr == i_region_addr);

  // Trailing ones of the region address plus the next zero give the size
  assign region_inc = i_region_addr + 32'd1;
  assign napot_span = i_region_addr ^ region_inc;
  assign napot_hit  = ((addr ^ i_region_addr) & ~napot_span) == 32'd0;

  always_comb begin
    case (i_mode)
      PMP_TOR:   o_hit = tor_hit;
      PMP_NA4:   o_hit = na4_hit;
      PMP_NAPOT: o_hit = napot_hit;
      default:   o_hit = 1'b0;  // OFF
    endcase
  end

endmodule

/* design/pmp_match_stage.sv */
/*
 * First check stage. Tests the request against every region and registers
 * the hit vector with the request fields; it never stalls.
 */
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_match_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         i_req_valid,
  input  logic [31:0]                  i_req_addr,
  input  pmp_pkg::access_kind_e        i_req_kind,
  input  logic [3:0]                   i_req_tag,
  input  pmp_pkg::priv_mode_e          i_priv,
  input  logic                         i_mprv,
  input  pmp_pkg::priv_mode_e          i_mpp,
  input  logic [8*`PMP_ENTRIES-1:0]    i_cfg_flat,
  input  logic [32*`PMP_ENTRIES-1:0]   i_addr_flat,
  output logic                         o_s1_valid,
  output logic [`PMP_ENTRIES-1:0]      o_s1_match,
  output pmp_pkg::access_kind_e        o_s1_kind,
  output logic [3:0]                   o_s1_tag,
  output pmp_pkg::priv_mode_e          o_s1_priv,
  output logic                         o_s1_mprv,
  output pmp_pkg::priv_mode_e          o_s1_mpp
);

  import pmp_pkg::*;

  logic [`PMP_ENTRIES-1:0] hit;

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_region
    pmp_cfg_t    cfg;
    logic [31:0] prev_addr;

    assign cfg = pmp_cfg_t'(i_cfg_flat[8*i +: 8]);

    if (i == 0) begin : g_first
      assign prev_addr = 32'd0;  // TOR base of entry 0
    end else begin : g_rest
      assign prev_addr = i_addr_flat[32*(i-1) +: 32];
    end

    pmp_region_match u_match (
      .i_word_addr   (i_req_addr[31:2]),
      .i_mode        (cfg.a),
      .i_region_addr (i_addr_flat[32*i +: 32]),
      .i_prev_addr   (prev_addr),
      .o_hit         (hit[i])
    );
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      o_s1_valid <= 1'b0;
    end else begin
      o_s1_valid <= i_req_valid;
    end
  end

  // Payload only, qualified by o_s1_valid downstream
  always_ff @(posedge CLK) begin
    if (i_req_valid) begin
      o_s1_match <= hit;
      o_s1_kind  <= i_req_kind;
      o_s1_tag   <= i_req_tag;
      o_s1_priv  <= i_priv;
      o_s1_mprv  <= i_mprv;
      o_s1_mpp   <= i_mpp;
    end
  end

endmodule

/* design/pmp_check_stage.sv */
/*
 * Second check stage. Picks the lowest matching region, applies the
 * privilege rules and queues responses, returning one credit per pop.
 */
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_check_stage (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         i_s1_valid,
  input  logic [`PMP_ENTRIES-1:0]      i_s1_match,
  input  pmp_pkg::access_kind_e        i_s1_kind,
  input  logic [3:0]                   i_s1_tag,
  input  pmp_pkg::priv_mode_e          i_s1_priv,
  input  logic                         i_s1_mprv,
  input  pmp_pkg::priv_mode_e          i_s1_mpp,
  input  logic [8*`PMP_ENTRIES-1:0]    i_cfg_flat,
  input  logic                         i_rsp_ready,
  output logic                         o_rsp_valid,
  output logic [3:0]                   o_rsp_tag,
  output pmp_pkg::access_kind_e        o_rsp_kind,
  output logic                         o_rsp_fault,
  output logic                         o_credit
);

  import pmp_pkg::*;

  localparam int DEPTH   = `PMP_CREDITS;
  localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  pmp_cfg_t [`PMP_ENTRIES-1:0] cfg;
  pmp_cfg_t       sel_cfg;
  logic           found;
  priv_mode_e     eff_priv;
  logic           perm;
  logic           fault;
  logic           push, pop, full;
  logic [PTR_W-1:0]   wr_ptr, rd_ptr;
  logic [COUNT_W-1:0] count;
  logic [3:0]     tag_mem   [DEPTH];
  access_kind_e   kind_mem  [DEPTH];
  logic           fault_mem [DEPTH];

  assign cfg = i_cfg_flat;

  // Lowest-numbered hit wins
  always_comb begin
    sel_cfg = '0;
    found   = 1'b0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (i_s1_match[i]) begin
        sel_cfg = cfg[i];
        found   = 1'b1;
      end
    end
  end

  // MPRV redirects data accesses only
  assign eff_priv = (i_s1_kind != ACC_FETCH && i_s1_mprv) ? i_s1_mpp : i_s1_priv;

  always_comb begin
    case (i_s1_kind)
      ACC_LOAD:  perm = sel_cfg.r;
      ACC_STORE: perm = sel_cfg.w;
      default:   perm = sel_cfg.x;
    endcase
    if (eff_priv != PRIV_M) begin
      fault = !found || !perm;
    end else begin
      fault = found && sel_cfg.l && !perm;  // M mode obeys locked regions only
    end
  end

  assign push = i_s1_valid;
  assign pop  = o_rsp_valid && i_rsp_ready;
  assign full = count == COUNT_W'(DEPTH);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count    <= count + COUNT_W'(push) - COUNT_W'(pop);
      o_credit <= pop;  // Credit goes back the cycle after the take
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      tag_mem[wr_ptr]   <= i_s1_tag;
      kind_mem[wr_ptr]  <= i_s1_kind;
      fault_mem[wr_ptr] <= fault;
    end
  end

  assign o_rsp_valid = count != '0;
  assign o_rsp_tag   = tag_mem[rd_ptr];
  assign o_rsp_kind  = kind_mem[rd_ptr];
  assign o_rsp_fault = fault_mem[rd_ptr];

  // Requester credit accounting keeps the buffer from overflowing
  a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
    push |-> !full)
    else $error("pmp_check_stage: push into full response buffer");

  a_rsp_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (o_rsp_valid && !i_rsp_ready) |=>
      (o_rsp_valid && $stable({o_rsp_tag, o_rsp_kind, o_rsp_fault})))
    else $error("pmp_check_stage: response changed under back-pressure");

endmodule

/* design/pmp_unit.sv */
/*
 * PMP unit top. CSR file beside a two-stage access-check pipeline
 * with credit-based request flow control.
 */
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   i_csr_en,
  input  logic                   i_csr_wen,
  input  logic [11:0]            i_csr_addr,
  input  logic [31:0]            i_csr_wdata,
  output logic [31:0]            o_csr_rdata,
  output logic                   o_csr_ack,
  input  logic                   i_req_valid,
  input  logic [31:0]            i_req_addr,
  input  pmp_pkg::access_kind_e  i_req_kind,
  input  logic [3:0]             i_req_tag,
  input  pmp_pkg::priv_mode_e    i_priv,
  input  logic                   i_mprv,
  input  pmp_pkg::priv_mode_e    i_mpp,
  output logic                   o_rsp_valid,
  output logic [3:0]             o_rsp_tag,
  output pmp_pkg::access_kind_e  o_rsp_kind,
  output logic                   o_rsp_fault,
  input  logic                   i_rsp_ready,
  output logic                   o_credit
);

  import pmp_pkg::*;

  logic [8*`PMP_ENTRIES-1:0]   cfg_flat;
  logic [32*`PMP_ENTRIES-1:0]  addr_flat;
  logic                        s1_valid;
  logic [`PMP_ENTRIES-1:0]     s1_match;
  access_kind_e                s1_kind;
  logic [3:0]                  s1_tag;
  priv_mode_e                  s1_priv, s1_mpp;
  logic                        s1_mprv;

  pmp_csr_file u_csr (
    .CLK(CLK), .nRST(nRST),
    .i_csr_en(i_csr_en), .i_csr_wen(i_csr_wen),
    .i_csr_addr(i_csr_addr), .i_csr_wdata(i_csr_wdata),
    .o_csr_rdata(o_csr_rdata), .o_csr_ack(o_csr_ack),
    .o_cfg_flat(cfg_flat), .o_addr_flat(addr_flat)
  );

  pmp_match_stage u_s1 (
    .CLK(CLK), .nRST(nRST),
    .i_req_valid(i_req_valid), .i_req_addr(i_req_addr),
    .i_req_kind(i_req_kind), .i_req_tag(i_req_tag),
    .i_priv(i_priv), .i_mprv(i_mprv), .i_mpp(i_mpp),
    .i_cfg_flat(cfg_flat), .i_addr_flat(addr_flat),
    .o_s1_valid(s1_valid), .o_s1_match(s1_match), .o_s1_kind(s1_kind),
    .o_s1_tag(s1_tag), .o_s1_priv(s1_priv), .o_s1_mprv(s1_mprv), .o_s1_mpp(s1_mpp)
  );

  pmp_check_stage u_s2 (
    .CLK(CLK), .nRST(nRST),
    .i_s1_valid(s1_valid), .i_s1_match(s1_match), .i_s1_kind(s1_kind),
    .i_s1_tag(s1_tag), .i_s1_priv(s1_priv), .i_s1_mprv(s1_mprv), .i_s1_mpp(s1_mpp),
    .i_cfg_flat(cfg_flat), .i_rsp_ready(i_rsp_ready),
    .o_rsp_valid(o_rsp_valid), .o_rsp_tag(o_rsp_tag), .o_rsp_kind(o_rsp_kind),
    .o_rsp_fault(o_rsp_fault), .o_credit(o_credit)
  );

endmodule

/* tb/pmp_unit_tb.sv */
/*
 * Testbench for the PMP unit. A reference model predicts CSR read-back and
 * fault results; concurrent assertions compare them with the DUT.
 */
`timescale 1ns/1ps
`include "pmp_defines.svh"

module pmp_unit_tb;

  import pmp_pkg::*;

  localparam int MAX_CYCLES = 3000;  // Several times the stimulus length

  logic CLK = 1'b0, nRST = 1'b0;
  logic i_csr_en, i_csr_wen, i_req_valid, i_mprv, i_rsp_ready;
  logic [11:0] i_csr_addr;
  logic [31:0] i_csr_wdata, i_req_addr, o_csr_rdata;
  access_kind_e i_req_kind, o_rsp_kind;
  logic [3:0] i_req_tag, o_rsp_tag;
  priv_mode_e i_priv, i_mpp;
  logic o_csr_ack, o_rsp_valid, o_rsp_fault, o_credit;

  logic [7:0]  m_cfg  [`PMP_ENTRIES];  // Model copy of the CSRs
  logic [31:0] m_addr [`PMP_ENTRIES];
  logic [3:0]  exp_tag   [256];        // Expected responses, oldest at rd_idx
  access_kind_e exp_kind [256];
  logic        exp_fault [256];
  int rd_idx = 0, wr_idx = 0, credits = `PMP_CREDITS;
  int errors = 0, taken = 0, cycles = 0, seed = 79626;
  int ready_seed = 79626;  // Back-pressure pattern
  logic exp_ack = 1'b0, rand_ready = 1'b0;
  logic [31:0] exp_rdata = '0;
  logic [3:0] next_tag = '0;

  pmp_unit uut (.*);

  always #2 CLK = ~CLK;

  // Reference model of the CSR write rules
  task automatic model_write(input logic [11:0] addr, input logic [31:0] data);
    logic [7:0] b;
    int idx;
    if (addr >= `PMP_CFG_BASE && addr < `PMP_CFG_BASE + `PMP_ENTRIES / 4) begin
      for (int k = 0; k < 4; k++) begin
        idx = (addr - `PMP_CFG_BASE) * 4 + k;
        b = data[8*k +: 8] & 8'h9F;       // Reserved bits 6:5 dropped
        if (!b[0]) b[1] = 1'b0;           // No W without R
        if (`PMP_GRAIN > 0 && b[4:3] == 2'b10) b[4:3] = 2'b11;
        if (!m_cfg[idx][7]) m_cfg[idx] = b;
      end
    end else if (addr >= `PMP_ADDR_BASE && addr < `PMP_ADDR_BASE + `PMP_ENTRIES) begin
      idx = addr - `PMP_ADDR_BASE;
      if (!m_cfg[idx][7] &&
          !(idx < `PMP_ENTRIES - 1 && m_cfg[idx+1][7] && m_cfg[idx+1][4:3] == 2'b01))
        m_addr[idx] = data;
    end
  endtask

  function automatic logic model_hit(input int i, input logic [31:0] word);
    int ones;
    logic [31:0] prev;
    prev = (i == 0) ? 32'd0 : m_addr[i-1];
    ones = 0;
    while (ones < 32 && m_addr[i][ones]) ones++;
    case (m_cfg[i][4:3])
      2'b01:   return word >= prev && word < m_addr[i];
      2'b10:   return word == m_addr[i];
      2'b11:   return ones >= 31 || (word >> (ones + 1)) == (m_addr[i] >> (ones + 1));
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic model_fault(input logic [31:0] addr, input access_kind_e kind,
                                       input priv_mode_e priv, input logic mprv,
                                       input priv_mode_e mpp);
    int sel;
    logic perm;
    priv_mode_e mode;
    sel = -1;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--)
      if (model_hit(i, {2'b00, addr[31:2]})) sel = i;
    mode = (kind != ACC_FETCH && mprv) ? mpp : priv;
    perm = (sel < 0) ? 1'b0 : m_cfg[sel][kind == ACC_LOAD ? 0 : kind == ACC_STORE ? 1 : 2];
    if (mode != PRIV_M) return sel < 0 || !perm;
    return sel >= 0 && m_cfg[sel][7] && !perm;
  endfunction

  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge CLK);
    i_csr_en <= 1'b1;
    i_csr_wen <= 1'b1;
    i_csr_addr <= addr;
    i_csr_wdata <= data;
    model_write(addr, data);
    @(posedge CLK);
    i_csr_en <= 1'b0;
    i_csr_wen <= 1'b0;
  endtask

  task automatic csr_read(input logic [11:0] addr);
    int idx;
    @(posedge CLK);
    i_csr_en <= 1'b1;
    i_csr_addr <= addr;
    exp_ack <= 1'b0;
    exp_rdata <= '0;
    if (addr >= `PMP_CFG_BASE && addr < `PMP_CFG_BASE + `PMP_ENTRIES / 4) begin
      idx = (addr - `PMP_CFG_BASE) * 4;
      exp_ack <= 1'b1;
      exp_rdata <= {m_cfg[idx+3], m_cfg[idx+2], m_cfg[idx+1], m_cfg[idx]};
    end else if (addr >= `PMP_ADDR_BASE && addr < `PMP_ADDR_BASE + `PMP_ENTRIES) begin
      exp_ack <= 1'b1;
      exp_rdata <= m_addr[addr - `PMP_ADDR_BASE];
    end
    @(posedge CLK);
    i_csr_en <= 1'b0;
  endtask

  task automatic read_all();
    csr_read(`PMP_CFG_BASE);
    csr_read(`PMP_CFG_BASE + 12'd1);
    for (int i = 0; i < `PMP_ENTRIES; i++) csr_read(`PMP_ADDR_BASE + 12'(i));
  endtask

  // Issues one request once a credit is free
  task automatic send(input logic [31:0] addr, input access_kind_e kind,
                      input priv_mode_e priv, input logic mprv, input priv_mode_e mpp);
    int avail;
    avail = 0;
    while (avail == 0) begin
      @(posedge CLK);
      avail = credits - int'(i_req_valid) + int'(o_credit);
      i_req_valid <= 1'b0;
    end
    i_req_valid <= 1'b1;
    i_req_addr <= addr;
    i_req_kind <= kind;
    i_req_tag <= next_tag;
    i_priv <= priv;
    i_mprv <= mprv;
    i_mpp <= mpp;
    exp_tag[wr_idx % 256] = next_tag;
    exp_kind[wr_idx % 256] = kind;
    exp_fault[wr_idx % 256] = model_fault(addr, kind, priv, mprv, mpp);
    wr_idx++;
    next_tag++;
  endtask

  task automatic send_random(input int n, input logic machine);
    access_kind_e kind;
    priv_mode_e priv, mpp;
    logic [31:0] addr;
    logic mprv;
    for (int i = 0; i < n; i++) begin
      kind = access_kind_e'(($random(seed) & 32'h7fff_ffff) % 3);
      priv = machine ? PRIV_M : (($random(seed) & 1) ? PRIV_S : PRIV_U);
      mpp = ($random(seed) & 1) ? PRIV_M : PRIV_U;
      addr = $random(seed) & 32'h0000_3FFF;
      mprv = machine & 1'($random(seed));
      send(addr, kind, priv, mprv, mpp);
    end
  endtask

  task automatic drain();
    @(posedge CLK);
    i_req_valid <= 1'b0;
    while (rd_idx != wr_idx) @(posedge CLK);
  endtask

  always @(posedge CLK) begin
    credits <= credits - int'(i_req_valid) + int'(o_credit);
    i_rsp_ready <= rand_ready ? 1'($random(ready_seed)) : 1'b1;
    if (o_rsp_valid && i_rsp_ready) begin
      rd_idx <= rd_idx + 1;
      taken <= taken + 1;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses pending", cycles, wr_idx - rd_idx);
      $display("TEST FAIL");
      $finish;
    end
  end

  a_rsp_tag: assert property (@(posedge CLK) disable iff (!nRST)
    (o_rsp_valid && i_rsp_ready) |-> o_rsp_tag == exp_tag[rd_idx % 256])
    else begin
      errors++;
      $display("mismatch o_rsp_tag: got %h expected %h",
               $sampled(o_rsp_tag), exp_tag[$sampled(rd_idx) % 256]);
    end
  a_rsp_kind: assert property (@(posedge CLK) disable iff (!nRST)
    (o_rsp_valid && i_rsp_ready) |-> o_rsp_kind == exp_kind[rd_idx % 256])
    else begin
      errors++;
      $display("mismatch o_rsp_kind: got %h expected %h",
               $sampled(o_rsp_kind), exp_kind[$sampled(rd_idx) % 256]);
    end
  a_rsp_fault: assert property (@(posedge CLK) disable iff (!nRST)
    (o_rsp_valid && i_rsp_ready) |-> o_rsp_fault == exp_fault[rd_idx % 256])
    else begin
      errors++;
      $display("mismatch o_rsp_fault: got %h expected %h",
               $sampled(o_rsp_fault), exp_fault[$sampled(rd_idx) % 256]);
    end
  a_no_spurious: assert property (@(posedge CLK) disable iff (!nRST)
    o_rsp_valid |-> rd_idx != wr_idx)
    else begin
      errors++;
      $display("response appeared with no request outstanding");
    end
  a_csr_ack: assert property (@(posedge CLK) disable iff (!nRST)
    (i_csr_en && !i_csr_wen) |-> o_csr_ack == exp_ack)
    else begin
      errors++;
      $display("mismatch o_csr_ack: got %h expected %h", $sampled(o_csr_ack), $sampled(exp_ack));
    end
  a_csr_rdata: assert property (@(posedge CLK) disable iff (!nRST)
    (i_csr_en && !i_csr_wen && exp_ack) |-> o_csr_rdata == exp_rdata)
    else begin
      errors++;
      $display("mismatch o_csr_rdata: got %h expected %h",
               $sampled(o_csr_rdata), $sampled(exp_rdata));
    end
  a_credit_range: assert property (@(posedge CLK) disable iff (!nRST)
    credits >= 0 && credits <= `PMP_CREDITS)
    else begin
      errors++;
      $display("credit count out of range: %0d", $sampled(credits));
    end
  a_credit_after_take: assert property (@(posedge CLK) disable iff (!nRST)
    (o_rsp_valid && i_rsp_ready) |=> o_credit)
    else begin
      errors++;
      $display("no credit pulse after a taken response");
    end
  a_credit_only_after_take: assert property (@(posedge CLK) disable iff (!nRST)
    o_credit |-> $past(o_rsp_valid && i_rsp_ready))
    else begin
      errors++;
      $display("credit pulse without a taken response");
    end

  initial begin
    {i_csr_en, i_csr_wen, i_req_valid, i_mprv, i_rsp_ready} = '0;
    i_csr_addr = '0;
    i_csr_wdata = '0;
    i_req_addr = '0;
    i_req_kind = ACC_LOAD;
    i_req_tag = '0;
    i_priv = PRIV_U;
    i_mpp = PRIV_U;
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      m_cfg[i] = '0;
      m_addr[i] = '0;
    end
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    repeat (5) @(posedge CLK);
    read_all();                               // Reset values
    csr_write(`PMP_CFG_BASE, 32'h7F7E_6266);  // Reserved bits and W without R
    csr_read(`PMP_CFG_BASE);
    csr_read(12'h3A5);                        // Unmapped
    csr_read(12'h3C0);
    csr_write(`PMP_CFG_BASE, 32'h0);
    csr_write(`PMP_ADDR_BASE + 12'd5, 32'h100);
    csr_write(`PMP_ADDR_BASE + 12'd6, 32'h200);
    csr_write(`PMP_CFG_BASE + 12'd1, 32'h0089_0000);  // Entry 6 locked TOR, R only
    csr_write(`PMP_ADDR_BASE + 12'd5, 32'h999);
    csr_write(`PMP_ADDR_BASE + 12'd6, 32'h777);
    csr_write(`PMP_ADDR_BASE + 12'd4, 32'hC00);
    csr_write(`PMP_ADDR_BASE + 12'd7, 32'hC47);
    csr_write(`PMP_CFG_BASE + 12'd1, 32'h9DFF_0F13);  // Entries 4, 5, 7 still writable and 7 locks
    read_all();
    // U-mode regions: TOR R/X, NA4 R/W, NAPOT R/W
    csr_write(`PMP_ADDR_BASE + 12'd0, 32'h400);
    csr_write(`PMP_ADDR_BASE + 12'd1, 32'h500);
    csr_write(`PMP_ADDR_BASE + 12'd2, 32'h807);
    csr_write(`PMP_CFG_BASE, 32'h001B_130D);
    read_all();
    rand_ready <= 1'b1;
    send(32'h0000_1400, ACC_STORE, PRIV_U, 1'b0, PRIV_U);
    send(32'h0000_3FF0, ACC_LOAD, PRIV_U, 1'b0, PRIV_U);  // No region
    send_random(40, 1'b0);
    send(32'h0000_0400, ACC_FETCH, PRIV_M, 1'b0, PRIV_M);  // Locked entry 6 is shadowed
    send(32'h0000_3FF0, ACC_LOAD, PRIV_M, 1'b1, PRIV_U);
    send(32'h0000_3FF0, ACC_FETCH, PRIV_M, 1'b1, PRIV_U);
    send(32'h0000_3110, ACC_STORE, PRIV_M, 1'b0, PRIV_M);  // Locked entry 7
    send_random(30, 1'b1);
    drain();
    csr_write(`PMP_CFG_BASE, 32'h0);  // Entry 6 now first match
    send(32'h0000_0500, ACC_FETCH, PRIV_M, 1'b0, PRIV_M);
    send_random(40, 1'b1);
    send_random(20, 1'b0);
    drain();
    repeat (5) @(posedge CLK);
    $display("responses=%0d expected=%0d errors=%0d", taken, wr_idx, errors);
    if (errors == 0 && taken == wr_idx) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* pmp_unit.f */
+incdir+design
design/pmp_pkg.sv
design/pmp_csr_file.sv
design/pmp_region_match.sv
design/pmp_match_stage.sv
design/pmp_check_stage.sv
design/pmp_unit.sv
tb/pmp_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the PMP unit testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f pmp_unit.f --top-module pmp_unit_tb \
  -o pmp_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/pmp_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log

[ -s sim.log ] && ! grep -q "TEST FAIL" sim.log && exit 0 || exit 1
